// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gat_writeback
FILELIST  ?= gat_writeback.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== gat_writeback.f ====
src/gat_pkg.sv
src/feat_fifo.sv
src/aggr_lane.sv
src/feature_controller.sv
src/gat_writeback_top.sv
tb/gat_writeback_sva.sv
tb/tb_gat_writeback.sv

// ==== src/aggr_lane.sv ====
`timescale 1ns/1ps

module aggr_lane (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic                                                          item_vld,
  input  logic [gat_pkg::ALPHA_DATA_WIDTH-1:0]                          alpha,
  input  logic [gat_pkg::HALF_FEATURES-1:0][gat_pkg::WH_DATA_WIDTH-1:0] wh_half,
  input  logic                                                          last,
  output gat_pkg::half_feat_t                                           half_out,
  output logic                                                          half_vld
);

  import gat_pkg::*;

  logic signed [NEW_FEATURE_WIDTH-1:0] wh_ext [HALF_FEATURES];
  logic signed [NEW_FEATURE_WIDTH-1:0] prod   [HALF_FEATURES];
  logic signed [ALPHA_DATA_WIDTH:0]    alpha_s;
  half_feat_t                          acc;
  half_feat_t                          sum_next;

  // Coefficient is unsigned, so a zero sign bit keeps the product signed
  assign alpha_s = {1'b0, alpha};

  // ============================================================
  // Multiply-accumulate per column
  // ============================================================
  always_comb begin
    for (int i = 0; i < HALF_FEATURES; i++) begin
      wh_ext[i]   = NEW_FEATURE_WIDTH'(signed'(wh_half[i]));
      prod[i]     = wh_ext[i] * alpha_s;
      sum_next[i] = acc[i] + prod[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc      <= '0;
      half_vld <= 1'b0;
    end else begin
      half_vld <= item_vld && last;
      if (item_vld) begin
        // Last node closes the subgraph and restarts from zero
        if (last) begin
          acc <= '0;
        end else begin
          acc <= sum_next;
        end
      end
    end
  end

  // Final sums include the product of the last node
  always_ff @(posedge clk) begin
    if (item_vld && last) begin
      half_out <= sum_next;
    end
  end

endmodule

// ==== src/feat_fifo.sv ====
`timescale 1ns/1ps

module feat_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  T                           din,
  input  logic                       wr,
  input  logic                       rd,
  output T                           dout,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] free
);

  T                           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   head;
  logic [$clog2(DEPTH)-1:0]   tail;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_wr;
  logic                       do_rd;

  // Requests beyond the current fill are ignored
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  assign empty = (count == '0);
  assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign free  = ($clog2(DEPTH+1))'(DEPTH) - count;

  // First word falls through
  assign dout  = mem[head];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[tail] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        tail <= (tail == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      if (do_rd) begin
        head <= (head == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : head + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/feature_controller.sv ====
`timescale 1ns/1ps

module feature_controller (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   gat_layer,
  input  gat_pkg::half_feat_t                    half_lo,
  input  gat_pkg::half_feat_t                    half_hi,
  input  logic                                   half_vld,
  output logic                                   vec_room,
  output logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0] feat_bram_addra,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]  feat_bram_din,
  output logic                                   feat_bram_ena,
  output logic                                   gat_ready
);

  import gat_pkg::*;

  feat_vec_t                           vec_din;
  feat_vec_t                           vec_dout;
  logic                                vec_rd;
  logic                                vec_empty;
  logic [$clog2(VEC_FIFO_DEPTH+1)-1:0] vec_free;

  feat_vec_t                           feat;
  feat_vec_t                           feat_reg;
  logic [$clog2(NUM_FEATURE_OUT)-1:0]  cnt;
  logic [$clog2(NUM_FEATURE_OUT)-1:0]  cnt_reg;
  logic [NEW_FEATURE_ADDR_W-1:0]       addr_reg;
  logic                                push_ena;
  logic [NEW_FEATURE_WIDTH-1:0]        elem;

  // ============================================================
  // Vector buffer
  // ============================================================
  assign vec_din = {half_hi, half_lo};

  feat_fifo #(
    .T     (feat_vec_t),
    .DEPTH (VEC_FIFO_DEPTH)
  ) u_vec_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (vec_din),
    .wr    (half_vld),
    .rd    (vec_rd),
    .dout  (vec_dout),
    .empty (vec_empty),
    .full  (),
    .free  (vec_free)
  );

  // Two free slots cover a vector still in the lane output registers
  assign vec_room = (vec_free >= 2);

  // ============================================================
  // Serializer
  // ============================================================
  assign vec_rd   = (cnt_reg == '0) && !vec_empty;
  assign feat     = vec_rd ? vec_dout : feat_reg;
  assign push_ena = vec_rd || (cnt_reg != '0);

  // Highest element goes out first
  assign elem = feat[NUM_FEATURE_OUT - 1 - int'(cnt_reg)];

  always_comb begin
    cnt = cnt_reg;
    if (push_ena) begin
      if (cnt_reg == ($clog2(NUM_FEATURE_OUT))'(NUM_FEATURE_OUT - 1)) begin
        cnt = '0;
      end else begin
        cnt = cnt_reg + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vec_rd) begin
      feat_reg <= vec_dout;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_reg  <= '0;
      addr_reg <= '0;
    end else begin
      cnt_reg <= cnt;
      if (push_ena) begin
        addr_reg <= addr_reg + 1'b1;
      end
    end
  end

  // ============================================================
  // BRAM port and layer completion
  // ============================================================
  always_ff @(posedge clk) begin
    if (push_ena) begin
      // Layer 1 halves each element
      feat_bram_din <= gat_layer ? (elem >> 1) : elem;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_bram_ena   <= 1'b0;
      feat_bram_addra <= '0;
      gat_ready       <= 1'b0;
    end else begin
      feat_bram_ena   <= push_ena;
      feat_bram_addra <= addr_reg;
      // Sticky until the next reset
      if (feat_bram_ena &&
          feat_bram_addra == NEW_FEATURE_ADDR_W'(NUM_SUBGRAPHS * NUM_FEATURE_OUT - 1)) begin
        gat_ready <= 1'b1;
      end
    end
  end

endmodule

// ==== src/gat_pkg.sv ====
package gat_pkg;

  // ============================================================
  // Layer dimensions
  // ============================================================
  localparam int NUM_FEATURE_OUT    = 4;
  localparam int HALF_FEATURES      = NUM_FEATURE_OUT / 2;
  localparam int NUM_SUBGRAPHS      = 6;

  // Element widths
  localparam int WH_DATA_WIDTH      = 8;
  localparam int ALPHA_DATA_WIDTH   = 8;
  localparam int NEW_FEATURE_WIDTH  = 24;

  // One feature row per subgraph in the BRAM
  localparam int NEW_FEATURE_ADDR_W = $clog2(NUM_SUBGRAPHS * NUM_FEATURE_OUT);

  // Buffer depths
  localparam int IN_FIFO_DEPTH      = 4;
  localparam int VEC_FIFO_DEPTH     = 4;

  // ============================================================
  // Payload types
  // ============================================================
  typedef struct packed {
    logic [ALPHA_DATA_WIDTH-1:0]                   alpha;
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh;
    logic                                          last;
  } node_item_t;

  // Accumulated half row from one lane
  typedef logic [HALF_FEATURES-1:0][NEW_FEATURE_WIDTH-1:0] half_feat_t;

  // Full row with element 0 in the low bits
  typedef logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] feat_vec_t;

endpackage

// ==== src/gat_writeback_top.sv ====
`timescale 1ns/1ps

module gat_writeback_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   gat_layer,
  input  gat_pkg::node_item_t                    node_in,
  input  logic                                   node_vld,
  output logic                                   node_rdy,
  output logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0] feat_bram_addra,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]  feat_bram_din,
  output logic                                   feat_bram_ena,
  output logic                                   gat_ready
);

  import gat_pkg::*;

  node_item_t in_head;
  logic       in_rd;
  logic       in_empty;
  logic       in_full;
  logic       vec_room;
  half_feat_t lo_half;
  half_feat_t hi_half;
  logic       lo_half_vld;
  logic       hi_half_vld;

  // ============================================================
  // Input buffer and pop gate
  // ============================================================
  feat_fifo #(
    .T     (node_item_t),
    .DEPTH (IN_FIFO_DEPTH)
  ) u_in_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (node_in),
    .wr    (node_vld),
    .rd    (in_rd),
    .dout  (in_head),
    .empty (in_empty),
    .full  (in_full),
    .free  ()
  );

  assign node_rdy = !in_full;

  // Hold items here while the vector buffer is short of space
  assign in_rd    = !in_empty && vec_room;

  // ============================================================
  // Aggregation lanes for the low and high feature columns
  // ============================================================
  aggr_lane u_lane_lo (
    .clk      (clk),
    .rst_n    (rst_n),
    .item_vld (in_rd),
    .alpha    (in_head.alpha),
    .wh_half  (in_head.wh[HALF_FEATURES-1:0]),
    .last     (in_head.last),
    .half_out (lo_half),
    .half_vld (lo_half_vld)
  );

  aggr_lane u_lane_hi (
    .clk      (clk),
    .rst_n    (rst_n),
    .item_vld (in_rd),
    .alpha    (in_head.alpha),
    .wh_half  (in_head.wh[NUM_FEATURE_OUT-1:HALF_FEATURES]),
    .last     (in_head.last),
    .half_out (hi_half),
    .half_vld (hi_half_vld)
  );

  // Lane 0 strobe drives the vector write
  feature_controller u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .gat_layer       (gat_layer),
    .half_lo         (lo_half),
    .half_hi         (hi_half),
    .half_vld        (lo_half_vld),
    .vec_room        (vec_room),
    .feat_bram_addra (feat_bram_addra),
    .feat_bram_din   (feat_bram_din),
    .feat_bram_ena   (feat_bram_ena),
    .gat_ready       (gat_ready)
  );

endmodule

// ==== tb/gat_writeback_sva.sv ====
`timescale 1ns/1ps

module gat_writeback_sva (
  input logic                                   clk,
  input logic                                   rst_n,
  input logic                                   node_vld,
  input logic                                   node_rdy,
  input logic                                   lo_half_vld,
  input logic                                   hi_half_vld,
  input logic                                   feat_bram_ena,
  input logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0] feat_bram_addra
);

  import gat_pkg::*;

  logic [NEW_FEATURE_ADDR_W-1:0] prev_addr;
  logic                          wrote_once;

  // Address of the previous BRAM write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_addr  <= '0;
      wrote_once <= 1'b0;
    end else if (feat_bram_ena) begin
      prev_addr  <= feat_bram_addra;
      wrote_once <= 1'b1;
    end
  end

  a_lanes_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) lo_half_vld == hi_half_vld
  ) else $error("Lane half_vld strobes differ");

  a_vld_needs_rdy: assert property (
    @(posedge clk) disable iff (!rst_n) node_vld |-> node_rdy
  ) else $error("node_vld high while node_rdy is low");

  a_addr_steps: assert property (
    @(posedge clk) disable iff (!rst_n)
      (feat_bram_ena && wrote_once) |-> (feat_bram_addra == prev_addr + 1'b1)
  ) else $error("BRAM address did not step by one");

endmodule

bind gat_writeback_top gat_writeback_sva u_sva (
  .clk             (clk),
  .rst_n           (rst_n),
  .node_vld        (node_vld),
  .node_rdy        (node_rdy),
  .lo_half_vld     (lo_half_vld),
  .hi_half_vld     (hi_half_vld),
  .feat_bram_ena   (feat_bram_ena),
  .feat_bram_addra (feat_bram_addra)
);

// ==== tb/tb_gat_writeback.sv ====
`timescale 1ns/1ps

module tb_gat_writeback;

  import gat_pkg::*;

  localparam int          MAX_NODES     = 5;
  localparam int          LAST_ADDR     = NUM_SUBGRAPHS * NUM_FEATURE_OUT - 1;
  localparam int          RDY_TIMEOUT   = 200;
  localparam int          DRAIN_TIMEOUT = 600;
  localparam int          READY_TIMEOUT = 10;
  localparam logic [31:0] SEED          = 32'd18;

  typedef struct packed {
    logic [NEW_FEATURE_ADDR_W-1:0] addr;
    logic [NEW_FEATURE_WIDTH-1:0]  data;
  } bram_wr_t;

  logic                          clk;
  logic                          rst_n;
  logic                          gat_layer;
  node_item_t                    node_in;
  logic                          node_vld;
  logic                          node_rdy;
  logic [NEW_FEATURE_ADDR_W-1:0] feat_bram_addra;
  logic [NEW_FEATURE_WIDTH-1:0]  feat_bram_din;
  logic                          feat_bram_ena;
  logic                          gat_ready;

  bram_wr_t    exp_q [$];
  node_item_t  sg_nodes [MAX_NODES];
  int          sg_len;
  int          next_addr;
  logic [31:0] rng_state;
  logic        armed;
  logic        final_seen;
  logic        rdy_low_seen;

  gat_writeback_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .gat_layer       (gat_layer),
    .node_in         (node_in),
    .node_vld        (node_vld),
    .node_rdy        (node_rdy),
    .feat_bram_addra (feat_bram_addra),
    .feat_bram_din   (feat_bram_din),
    .feat_bram_ena   (feat_bram_ena),
    .gat_ready       (gat_ready)
  );

  always #10 clk = ~clk;

  // ============================================================
  // Random source and reference model
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Sum of alpha times WH over the subgraph with the layer 1 halving
  function automatic logic [NEW_FEATURE_WIDTH-1:0] ref_feature(
    input node_item_t nodes [MAX_NODES],
    input int         n,
    input int         col,
    input logic       layer
  );
    int                           acc;
    logic [NEW_FEATURE_WIDTH-1:0] res;
    acc = 0;
    for (int k = 0; k < n; k++) begin
      acc += int'($signed(nodes[k].wh[col])) * int'(nodes[k].alpha);
    end
    res = acc[NEW_FEATURE_WIDTH-1:0];
    return layer ? {1'b0, res[NEW_FEATURE_WIDTH-1:1]} : res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
      $display("Regression failed");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("Regression failed");
    $fatal(1, "Stopping at the first error");
  endtask

  // ============================================================
  // BRAM write and completion checker
  // ============================================================
  always @(negedge clk) begin
    bram_wr_t want;
    if (armed) begin
      check_value("gat_ready", 32'(gat_ready), 32'(final_seen));
    end
    if (feat_bram_ena) begin
      if (exp_q.size() == 0) begin
        stop_with_error($sformatf("BRAM write to address %0d was not expected",
                                  feat_bram_addra));
      end else begin
        want = exp_q.pop_front();
        check_value("feat_bram_addra", 32'(feat_bram_addra), 32'(want.addr));
        check_value("feat_bram_din", 32'(feat_bram_din), 32'(want.data));
        if (int'(want.addr) == LAST_ADDR) begin
          final_seen = 1'b1;
        end
      end
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic apply_reset();
    armed = 1'b0;
    @(negedge clk);
    rst_n      = 1'b0;
    final_seen = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("node_rdy", 32'(node_rdy), 32'd1);
    check_value("feat_bram_ena", 32'(feat_bram_ena), 32'd0);
    check_value("gat_ready", 32'(gat_ready), 32'd0);
    check_value("half_vld", 32'({dut0.lo_half_vld, dut0.hi_half_vld}), 32'd0);
    armed = 1'b1;
  endtask

  task automatic send_node(input node_item_t item);
    int waited;
    waited = 0;
    while (!node_rdy) begin
      rdy_low_seen = 1'b1;
      @(negedge clk);
      waited++;
      if (waited > RDY_TIMEOUT) begin
        stop_with_error("node_rdy stayed low, the input FIFO never drained");
      end
    end
    node_in  = item;
    node_vld = 1'b1;
    @(negedge clk);
    node_vld = 1'b0;
  endtask

  // Directed mode gives extreme values, then a single-node burst and a full subgraph
  task automatic make_subgraph(input int s, input bit directed);
    logic [31:0] r;
    r = next_rand();
    if (!directed) begin
      sg_len = int'(r % 32'(MAX_NODES)) + 1;
    end else if (s >= 1 && s <= 4) begin
      sg_len = 1;
    end else begin
      sg_len = MAX_NODES;
    end
    for (int k = 0; k < sg_len; k++) begin
      sg_nodes[k].alpha = next_rand() >> 24;
      r = next_rand();
      for (int e = 0; e < NUM_FEATURE_OUT; e++) begin
        sg_nodes[k].wh[e] = r[8*e +: 8];
      end
      sg_nodes[k].last = (k == sg_len - 1);
      if (directed && s == 0) begin
        sg_nodes[k].alpha = 8'hFF;
        sg_nodes[k].wh[0] = 8'h80;
        sg_nodes[k].wh[1] = 8'(-(k + 1));
        sg_nodes[k].wh[3] = 8'h80 | 8'(k);
      end
    end
  endtask

  task automatic send_subgraph(input bit gaps);
    bram_wr_t    wr;
    logic [31:0] r;
    // Highest element is written first
    for (int col = NUM_FEATURE_OUT - 1; col >= 0; col--) begin
      wr.addr = NEW_FEATURE_ADDR_W'(next_addr);
      wr.data = ref_feature(sg_nodes, sg_len, col, gat_layer);
      exp_q.push_back(wr);
      next_addr++;
    end
    for (int k = 0; k < sg_len; k++) begin
      send_node(sg_nodes[k]);
      r = next_rand();
      if (gaps && r[1:0] == 2'b00) begin
        repeat (int'(r[4:2]) + 1) @(negedge clk);
      end
    end
  endtask

  task automatic run_layer(input logic layer, input bit directed);
    int waited;
    gat_layer = layer;
    apply_reset();
    next_addr    = 0;
    rdy_low_seen = 1'b0;
    for (int s = 0; s < NUM_SUBGRAPHS; s++) begin
      make_subgraph(s, directed);
      send_subgraph(!directed);
    end
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_with_error("expected BRAM writes never appeared");
      end
    end
    waited = 0;
    while (!gat_ready) begin
      @(negedge clk);
      waited++;
      if (waited > READY_TIMEOUT) begin
        stop_with_error("gat_ready never rose after the last write");
      end
    end
    // Checker keeps watching gat_ready stay high
    repeat (4) @(negedge clk);
    if (directed) begin
      check_value("node_rdy_low_seen", 32'(rdy_low_seen), 32'd1);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    gat_layer = 1'b0;
    node_in   = '0;
    node_vld  = 1'b0;
    armed     = 1'b0;
    final_seen   = 1'b0;
    rdy_low_seen = 1'b0;
    rng_state = SEED;
    run_layer(1'b0, 1'b0);
    run_layer(1'b0, 1'b1);
    // Same random stimulus again in the halving layer
    rng_state = SEED;
    run_layer(1'b1, 1'b0);
    run_layer(1'b1, 1'b1);
    $display("Regression passed");
    $finish;
  end

endmodule
